// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // ************************************************************
    // bus widths
    // ************************************************************
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;

    // AXI style response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // ************************************************************
    // memory map
    // ************************************************************
    localparam addr_t MEM_BASE  = 32'h8000_0000;
    localparam addr_t MEM_LIMIT = 32'h8800_0000;

    // 4 KiB of backing store, higher address bits alias
    localparam int MEM_WORDS  = 512;
    localparam int WORD_IDX_W = $clog2(MEM_WORDS);
    localparam int WORD_LSB   = $clog2(STRB_W);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_DATA
    } arb_state_e;

    typedef enum logic [1:0] {
        SRAM_IDLE,
        SRAM_READ_RESP,
        SRAM_WRITE_RESP
    } sram_state_e;

endpackage

`default_nettype wire

// File: rtl/mem_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_rd_if;
    import mem_pkg::*;

    // read address channel
    logic  ar_valid;
    addr_t ar_addr;
    logic  ar_ready;

    // read data channel
    logic  r_valid;
    logic  r_ready;
    data_t r_data;
    resp_t r_resp;

    modport requester (
        output ar_valid,
        output ar_addr,
        input  ar_ready,
        input  r_valid,
        output r_ready,
        input  r_data,
        input  r_resp
    );

    modport responder (
        input  ar_valid,
        input  ar_addr,
        output ar_ready,
        output r_valid,
        input  r_ready,
        output r_data,
        output r_resp
    );

endinterface

`default_nettype wire

// File: rtl/mem_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_wr_if;
    import mem_pkg::*;

    // address and data go out together under one valid
    logic  aw_valid;
    addr_t aw_addr;
    data_t w_data;
    strb_t w_strb;
    logic  aw_ready;

    // write response
    logic  b_valid;
    logic  b_ready;
    resp_t b_resp;

    modport requester (
        output aw_valid,
        output aw_addr,
        output w_data,
        output w_strb,
        input  aw_ready,
        input  b_valid,
        output b_ready,
        input  b_resp
    );

    modport responder (
        input  aw_valid,
        input  aw_addr,
        input  w_data,
        input  w_strb,
        output aw_ready,
        output b_valid,
        input  b_ready,
        output b_resp
    );

endinterface

`default_nettype wire

// File: rtl/mem_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_read_arbiter (
    input  wire         clk,
    input  wire         arst_n_i,
    mem_rd_if.responder fetch_rd,
    mem_rd_if.responder data_rd,
    mem_rd_if.requester mem_rd
);
    import mem_pkg::*;

    arb_state_e state_q;
    arb_state_e state_d;

    logic idle;
    logic mem_ar_fire;
    logic mem_r_fire;

    assign idle        = (state_q == ARB_IDLE);
    assign mem_ar_fire = mem_rd.ar_valid && mem_rd.ar_ready;
    assign mem_r_fire  = mem_rd.r_valid && mem_rd.r_ready;

    // ************************************************************
    // address side
    // ************************************************************

    // only forwarded while idle, no register in the path
    assign mem_rd.ar_valid = idle && (data_rd.ar_valid || fetch_rd.ar_valid);

    // load/store has priority over fetch
    assign mem_rd.ar_addr = data_rd.ar_valid ? data_rd.ar_addr : fetch_rd.ar_addr;

    assign data_rd.ar_ready  = idle && mem_rd.ar_ready;
    assign fetch_rd.ar_ready = idle && mem_rd.ar_ready && !data_rd.ar_valid;

    // ************************************************************
    // response side
    // ************************************************************

    // payload is shared, the valid tells who owns it
    assign fetch_rd.r_data = mem_rd.r_data;
    assign fetch_rd.r_resp = mem_rd.r_resp;
    assign data_rd.r_data  = mem_rd.r_data;
    assign data_rd.r_resp  = mem_rd.r_resp;

    always_comb begin
        fetch_rd.r_valid = 1'b0;
        data_rd.r_valid  = 1'b0;
        mem_rd.r_ready   = 1'b0;
        case (state_q)
            ARB_FETCH: begin
                fetch_rd.r_valid = mem_rd.r_valid;
                mem_rd.r_ready   = fetch_rd.r_ready;
            end
            ARB_DATA: begin
                data_rd.r_valid = mem_rd.r_valid;
                mem_rd.r_ready  = data_rd.r_ready;
            end
            default: begin
                mem_rd.r_ready = 1'b0;
            end
        endcase
    end

    // grant held until the response is taken
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (mem_ar_fire) begin
                    state_d = data_rd.ar_valid ? ARB_DATA : ARB_FETCH;
                end
            end
            ARB_FETCH,
            ARB_DATA: begin
                if (mem_r_fire) begin
                    state_d = ARB_IDLE;
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the sram must not answer a read the arbiter never granted
    a_no_resp_in_idle: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        idle |-> !mem_rd.r_valid
    );

    // a port without its own address handshake gets no response
    a_resp_to_grant_only: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        mem_ar_fire |=>
            (($past(fetch_rd.ar_valid && fetch_rd.ar_ready) || !fetch_rd.r_valid) &&
             ($past(data_rd.ar_valid && data_rd.ar_ready) || !data_rd.r_valid))
    );

    // a granted read gets its response on the next cycle
    a_grant_then_resp: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        mem_ar_fire |=> mem_rd.r_valid
    );

endmodule

`default_nettype wire

// File: rtl/sram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl (
    input  wire         clk,
    input  wire         arst_n_i,
    mem_rd_if.responder rd,
    mem_wr_if.responder wr
);
    import mem_pkg::*;

    sram_state_e state_q;
    sram_state_e state_d;

    data_t mem_q [MEM_WORDS];

    logic                  rd_fire;
    logic                  wr_fire;
    logic                  rd_hit;
    logic                  wr_hit;
    logic [WORD_IDX_W-1:0] rd_idx;
    logic [WORD_IDX_W-1:0] wr_idx;

    data_t r_data_q;
    resp_t r_resp_q;
    resp_t b_resp_q;

    function automatic logic in_window(addr_t addr);
        return (addr >= MEM_BASE) && (addr < MEM_LIMIT);
    endfunction

    // ************************************************************
    // request acceptance
    // ************************************************************

    // a write in the same cycle as a read wins
    assign wr.aw_ready = (state_q == SRAM_IDLE);
    assign rd.ar_ready = (state_q == SRAM_IDLE) && !wr.aw_valid;

    assign wr_fire = wr.aw_valid && wr.aw_ready;
    assign rd_fire = rd.ar_valid && rd.ar_ready;

    assign rd_hit = in_window(rd.ar_addr);
    assign wr_hit = in_window(wr.aw_addr);
    assign rd_idx = rd.ar_addr[WORD_LSB +: WORD_IDX_W];
    assign wr_idx = wr.aw_addr[WORD_LSB +: WORD_IDX_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            SRAM_IDLE: begin
                if (wr_fire) begin
                    state_d = SRAM_WRITE_RESP;
                end else if (rd_fire) begin
                    state_d = SRAM_READ_RESP;
                end
            end
            SRAM_READ_RESP: begin
                if (rd.r_ready) begin
                    state_d = SRAM_IDLE;
                end
            end
            SRAM_WRITE_RESP: begin
                if (wr.b_ready) begin
                    state_d = SRAM_IDLE;
                end
            end
            default: begin
                state_d = SRAM_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= SRAM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ************************************************************
    // array and response payload
    // ************************************************************

    // byte merge under strobe, outside the window nothing changes
    always_ff @(posedge clk) begin
        if (wr_fire && wr_hit) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr.w_strb[b]) begin
                    mem_q[wr_idx][8*b +: 8] <= wr.w_data[8*b +: 8];
                end
            end
        end
    end

    // captured once at acceptance, held through back-pressure
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            r_data_q <= rd_hit ? mem_q[rd_idx] : '0;
            r_resp_q <= rd_hit ? RESP_OKAY : RESP_DECERR;
        end
        if (wr_fire) begin
            b_resp_q <= wr_hit ? RESP_OKAY : RESP_DECERR;
        end
    end

    assign rd.r_valid = (state_q == SRAM_READ_RESP);
    assign rd.r_data  = r_data_q;
    assign rd.r_resp  = r_resp_q;

    assign wr.b_valid = (state_q == SRAM_WRITE_RESP);
    assign wr.b_resp  = b_resp_q;

    a_one_resp_at_a_time: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(rd.r_valid && wr.b_valid)
    );

    // response held steady while the requester stalls
    a_r_stable: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (rd.r_valid && !rd.r_ready) |=>
            (rd.r_valid && $stable(rd.r_data) && $stable(rd.r_resp))
    );

endmodule

`default_nettype wire

// File: rtl/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  wire                  clk,
    input  wire                  arst_n_i,

    // instruction fetch read port
    input  wire                  if_ar_valid_i,
    input  wire mem_pkg::addr_t  if_ar_addr_i,
    output wire                  if_ar_ready_o,
    output wire                  if_r_valid_o,
    input  wire                  if_r_ready_i,
    output wire mem_pkg::data_t  if_r_data_o,
    output wire mem_pkg::resp_t  if_r_resp_o,

    // load/store port
    input  wire                  ls_ar_valid_i,
    input  wire mem_pkg::addr_t  ls_ar_addr_i,
    output wire                  ls_ar_ready_o,
    output wire                  ls_r_valid_o,
    input  wire                  ls_r_ready_i,
    output wire mem_pkg::data_t  ls_r_data_o,
    output wire mem_pkg::resp_t  ls_r_resp_o,
    input  wire                  ls_aw_valid_i,
    input  wire mem_pkg::addr_t  ls_aw_addr_i,
    input  wire mem_pkg::data_t  ls_w_data_i,
    input  wire mem_pkg::strb_t  ls_w_strb_i,
    output wire                  ls_aw_ready_o,
    output wire                  ls_b_valid_o,
    input  wire                  ls_b_ready_i,
    output wire mem_pkg::resp_t  ls_b_resp_o
);

    mem_rd_if fetch_rd ();
    mem_rd_if data_rd ();
    mem_rd_if mem_rd ();
    mem_wr_if data_wr ();

    // ************************************************************
    // plain ports to channels
    // ************************************************************
    assign fetch_rd.ar_valid = if_ar_valid_i;
    assign fetch_rd.ar_addr  = if_ar_addr_i;
    assign fetch_rd.r_ready  = if_r_ready_i;
    assign if_ar_ready_o     = fetch_rd.ar_ready;
    assign if_r_valid_o      = fetch_rd.r_valid;
    assign if_r_data_o       = fetch_rd.r_data;
    assign if_r_resp_o       = fetch_rd.r_resp;

    assign data_rd.ar_valid = ls_ar_valid_i;
    assign data_rd.ar_addr  = ls_ar_addr_i;
    assign data_rd.r_ready  = ls_r_ready_i;
    assign ls_ar_ready_o    = data_rd.ar_ready;
    assign ls_r_valid_o     = data_rd.r_valid;
    assign ls_r_data_o      = data_rd.r_data;
    assign ls_r_resp_o      = data_rd.r_resp;

    // writes bypass the arbiter
    assign data_wr.aw_valid = ls_aw_valid_i;
    assign data_wr.aw_addr  = ls_aw_addr_i;
    assign data_wr.w_data   = ls_w_data_i;
    assign data_wr.w_strb   = ls_w_strb_i;
    assign data_wr.b_ready  = ls_b_ready_i;
    assign ls_aw_ready_o    = data_wr.aw_ready;
    assign ls_b_valid_o     = data_wr.b_valid;
    assign ls_b_resp_o      = data_wr.b_resp;

    mem_read_arbiter mem_read_arbiter_i (
        .clk      ( clk      ),
        .arst_n_i ( arst_n_i ),
        .fetch_rd ( fetch_rd ),
        .data_rd  ( data_rd  ),
        .mem_rd   ( mem_rd   )
    );

    sram_ctrl sram_ctrl_i (
        .clk      ( clk      ),
        .arst_n_i ( arst_n_i ),
        .rd       ( mem_rd   ),
        .wr       ( data_wr  )
    );

endmodule

`default_nettype wire

// File: sim/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int TIMEOUT = 20;
    localparam addr_t BAD_ADDR [4] = '{
        32'h7FFF_FFF8, 32'h8800_0000, 32'hFFFF_FFF0, 32'h0000_0040
    };

    logic  clk;
    logic  arst_n_i;
    logic  if_ar_valid_i;
    addr_t if_ar_addr_i;
    logic  if_ar_ready_o;
    logic  if_r_valid_o;
    logic  if_r_ready_i;
    data_t if_r_data_o;
    resp_t if_r_resp_o;
    logic  ls_ar_valid_i;
    addr_t ls_ar_addr_i;
    logic  ls_ar_ready_o;
    logic  ls_r_valid_o;
    logic  ls_r_ready_i;
    data_t ls_r_data_o;
    resp_t ls_r_resp_o;
    logic  ls_aw_valid_i;
    addr_t ls_aw_addr_i;
    data_t ls_w_data_i;
    strb_t ls_w_strb_i;
    logic  ls_aw_ready_o;
    logic  ls_b_valid_o;
    logic  ls_b_ready_i;
    resp_t ls_b_resp_o;

    // read port picked by read_word
    logic  use_fetch;
    logic  sel_ar_ready;
    logic  sel_r_valid;
    data_t sel_r_data;
    resp_t sel_r_resp;

    data_t model_mem [MEM_WORDS];
    bit    model_written [MEM_WORDS];
    addr_t addr_q [$];
    int    seed = 66;
    int    errors = 0;
    int    test_errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;

    assign sel_ar_ready = use_fetch ? if_ar_ready_o : ls_ar_ready_o;
    assign sel_r_valid  = use_fetch ? if_r_valid_o : ls_r_valid_o;
    assign sel_r_data   = use_fetch ? if_r_data_o : ls_r_data_o;
    assign sel_r_resp   = use_fetch ? if_r_resp_o : ls_r_resp_o;

    mem_subsys_top mem_subsys_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ************************************************************
    // port protocol checks
    // ************************************************************
    a_read_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((ls_ar_valid_i && ls_ar_ready_o) || (if_ar_valid_i && if_ar_ready_o)) |=>
            (ls_r_valid_o || if_r_valid_o))
        else note_mismatch("read response not one cycle after its address");

    a_write_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        (ls_aw_valid_i && ls_aw_ready_o) |=> ls_b_valid_o)
        else note_mismatch("write response not one cycle after its address");

    a_one_read_resp: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(ls_r_valid_o && if_r_valid_o))
        else note_mismatch("both read ports see a response");

    a_ls_r_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        (ls_r_valid_o && !ls_r_ready_i) |=>
            (ls_r_valid_o && $stable(ls_r_data_o) && $stable(ls_r_resp_o)))
        else note_mismatch("data read response changed while stalled");

    a_if_r_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        (if_r_valid_o && !if_r_ready_i) |=>
            (if_r_valid_o && $stable(if_r_data_o) && $stable(if_r_resp_o)))
        else note_mismatch("fetch read response changed while stalled");

    a_b_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        (ls_b_valid_o && !ls_b_ready_i) |=> (ls_b_valid_o && $stable(ls_b_resp_o)))
        else note_mismatch("write response changed while stalled");

    function automatic void note_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        errors++;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("Something failed");
        $finish;
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic bit in_map(input addr_t addr);
        return (addr >= MEM_BASE) && (addr < MEM_LIMIT);
    endfunction

    function automatic int word_of(input addr_t addr);
        return int'((addr >> WORD_LSB) % MEM_WORDS);
    endfunction

    function automatic void end_test(input string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endfunction

    function automatic void check_read(input addr_t addr, input data_t data, input resp_t resp);
        int w;
        w = word_of(addr);
        if (in_map(addr)) begin
            assert (resp == RESP_OKAY)
                else note_mismatch($sformatf("read %h gave response %0d", addr, resp));
            if (model_written[w]) begin
                assert (data == model_mem[w]) else note_mismatch(
                    $sformatf("read %h gave %h, expected %h", addr, data, model_mem[w]));
            end
        end else begin
            assert (resp == RESP_DECERR && data == '0) else note_mismatch(
                $sformatf("read %h outside the map gave %h, response %0d", addr, data, resp));
        end
    endfunction

    // ************************************************************
    // single transfers with optional back-pressure
    // ************************************************************
    task automatic read_word(input bit fetch, input addr_t addr, input int hold,
                             output data_t data, output resp_t resp);
        int n;
        use_fetch = fetch;
        if (fetch) begin
            if_ar_valid_i = 1'b1;
            if_ar_addr_i  = addr;
            if_r_ready_i  = (hold == 0);
        end else begin
            ls_ar_valid_i = 1'b1;
            ls_ar_addr_i  = addr;
            ls_r_ready_i  = (hold == 0);
        end
        #1;
        n = 0;
        while (!sel_ar_ready) begin
            step();
            n++;
            if (n > TIMEOUT) report_timeout("read address was never accepted");
        end
        step();
        if_ar_valid_i = 1'b0;
        ls_ar_valid_i = 1'b0;
        n = 0;
        while (!sel_r_valid) begin
            step();
            n++;
            if (n > TIMEOUT) report_timeout("read response never arrived");
        end
        assert (n == 0) else note_mismatch("read response came late");
        data = sel_r_data;
        resp = sel_r_resp;
        repeat (hold) begin
            step();
            assert (sel_r_valid && sel_r_data == data && sel_r_resp == resp)
                else note_mismatch("read response lost or changed under back-pressure");
        end
        if_r_ready_i = 1'b1;
        ls_r_ready_i = 1'b1;
        step();
        if_r_ready_i = 1'b0;
        ls_r_ready_i = 1'b0;
        assert (!sel_r_valid) else note_mismatch("read response repeated after its handshake");
        step();
    endtask

    task automatic write_word(input addr_t addr, input data_t data, input strb_t strb,
                              input int hold);
        int n;
        int w;
        resp_t resp;
        ls_aw_valid_i = 1'b1;
        ls_aw_addr_i  = addr;
        ls_w_data_i   = data;
        ls_w_strb_i   = strb;
        ls_b_ready_i  = (hold == 0);
        #1;
        n = 0;
        while (!ls_aw_ready_o) begin
            step();
            n++;
            if (n > TIMEOUT) report_timeout("write address was never accepted");
        end
        step();
        ls_aw_valid_i = 1'b0;
        // model update at the accepted handshake
        if (in_map(addr)) begin
            w = word_of(addr);
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (strb[b]) begin
                    model_mem[w][8*b +: 8] = data[8*b +: 8];
                end
            end
            model_written[w] = model_written[w] | (&strb);
        end
        n = 0;
        while (!ls_b_valid_o) begin
            step();
            n++;
            if (n > TIMEOUT) report_timeout("write response never arrived");
        end
        assert (n == 0) else note_mismatch("write response came late");
        resp = ls_b_resp_o;
        repeat (hold) begin
            step();
            assert (ls_b_valid_o && ls_b_resp_o == resp)
                else note_mismatch("write response lost or changed under back-pressure");
        end
        ls_b_ready_i = 1'b1;
        step();
        ls_b_ready_i = 1'b0;
        assert (!ls_b_valid_o) else note_mismatch("write response repeated after its handshake");
        assert (resp == (in_map(addr) ? RESP_OKAY : RESP_DECERR))
            else note_mismatch($sformatf("write %h gave response %0d", addr, resp));
        step();
    endtask

    initial begin
        data_t d;
        resp_t r;
        addr_t a;
        int    k;
        int    ls_at;
        int    if_at;
        bit    ls_go;
        bit    if_go;
        arst_n_i      = 1'b0;
        use_fetch     = 1'b0;
        if_ar_valid_i = 1'b0;
        if_ar_addr_i  = '0;
        if_r_ready_i  = 1'b0;
        ls_ar_valid_i = 1'b0;
        ls_ar_addr_i  = '0;
        ls_r_ready_i  = 1'b0;
        ls_aw_valid_i = 1'b0;
        ls_aw_addr_i  = '0;
        ls_w_data_i   = '0;
        ls_w_strb_i   = '0;
        ls_b_ready_i  = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        #1;
        assert (!if_r_valid_o && !ls_r_valid_o && !ls_b_valid_o)
            else note_mismatch("a valid output is high after reset");
        assert (if_ar_ready_o && ls_ar_ready_o && ls_aw_ready_o)
            else note_mismatch("a ready output is low after reset");
        step();
        read_word(1'b0, MEM_BASE + 32'h100, 0, d, r);
        check_read(MEM_BASE + 32'h100, d, r);
        write_word(MEM_BASE + 32'h108, {$random(seed), $random(seed)}, '1, 0);
        end_test("reset_and_latency");

        // full word first so every byte is known, then a random strobe on top
        for (int i = 0; i < 8; i++) begin
            a = MEM_BASE | (addr_t'($random(seed)) & 32'h07FF_FFF8);
            addr_q.push_back(a);
            write_word(a, {$random(seed), $random(seed)}, '1, 0);
            write_word(a, {$random(seed), $random(seed)}, strb_t'($random(seed)), 0);
        end
        foreach (addr_q[i]) begin
            read_word(1'b0, addr_q[i], 0, d, r);
            check_read(addr_q[i], d, r);
        end
        end_test("data_write_readback");

        foreach (addr_q[i]) begin
            read_word(1'b1, addr_q[i], 0, d, r);
            check_read(addr_q[i], d, r);
        end
        end_test("shared_memory_fetch");

        for (int i = 0; i < 4; i++) begin
            a = MEM_BASE | (BAD_ADDR[i] & 32'h0FF8);
            write_word(a, {$random(seed), $random(seed)}, '1, 0);
            write_word(BAD_ADDR[i], ~model_mem[word_of(a)], '1, 0);
            read_word(1'b0, BAD_ADDR[i], 0, d, r);
            check_read(BAD_ADDR[i], d, r);
            read_word(1'b0, a, 0, d, r);
            check_read(a, d, r);
        end
        end_test("window_check");

        ls_ar_valid_i = 1'b1;
        ls_ar_addr_i  = addr_q[0];
        ls_r_ready_i  = 1'b1;
        if_ar_valid_i = 1'b1;
        if_ar_addr_i  = addr_q[1];
        if_r_ready_i  = 1'b1;
        ls_at = -1;
        if_at = -1;
        k = 0;
        while (ls_at < 0 || if_at < 0) begin
            #1;
            if (k == 0) begin
                assert (ls_ar_ready_o && !if_ar_ready_o)
                    else note_mismatch("fetch was not held off by a data read");
            end
            if (ls_r_valid_o && ls_at < 0) begin
                ls_at = k;
                check_read(ls_ar_addr_i, ls_r_data_o, ls_r_resp_o);
            end
            if (if_r_valid_o && if_at < 0) begin
                if_at = k;
                check_read(if_ar_addr_i, if_r_data_o, if_r_resp_o);
            end
            ls_go = ls_ar_valid_i && ls_ar_ready_o;
            if_go = if_ar_valid_i && if_ar_ready_o;
            step();
            if (ls_go) ls_ar_valid_i = 1'b0;
            if (if_go) if_ar_valid_i = 1'b0;
            k++;
            if (k > TIMEOUT) report_timeout("contended reads did not both complete");
        end
        ls_r_ready_i = 1'b0;
        if_r_ready_i = 1'b0;
        assert (ls_at < if_at) else note_mismatch("fetch response came before the data response");
        step();
        end_test("read_priority");

        for (int i = 0; i < 4; i++) begin
            k = 1 + int'({$random(seed)} % 4);
            read_word((i % 2) == 1, addr_q[i], k, d, r);
            check_read(addr_q[i], d, r);
            write_word(addr_q[i], {$random(seed), $random(seed)}, strb_t'($random(seed)), k);
        end
        end_test("back_pressure");

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
rtl/mem_pkg.sv
rtl/mem_rd_if.sv
rtl/mem_wr_if.sv
rtl/mem_read_arbiter.sv
rtl/sram_ctrl.sv
rtl/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_mem_subsys
FILELIST  := filelist.f
FLAGS     := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
